// ==== vga_timing_pkg.sv ====
package vga_timing_pkg;

  // reduced video mode so that whole frames simulate in a few thousand cycles
  // a full 640x480 mode only changes the numbers below

  // horizontal timing, counted in pixels
  localparam int h_visible     = 16;
  localparam int h_front_porch = 2;
  localparam int h_sync_pulse  = 3;
  localparam int h_back_porch  = 3;
  localparam int h_whole_line  = 24;

  // vertical timing, counted in lines
  localparam int v_visible     = 8;
  localparam int v_front_porch = 1;
  localparam int v_sync_pulse  = 2;
  localparam int v_back_porch  = 1;
  localparam int v_whole_frame = 12;

  // standard vga drives both sync lines low during the pulse
  localparam logic sync_active_low = 1'b1;

  // scan coordinates cover the blanking area as well as the visible one
  typedef logic [$clog2(h_whole_line)-1:0]  col_t;
  typedef logic [$clog2(v_whole_frame)-1:0] row_t;

  // the scan counter compares against these, sized to its own coordinates
  localparam col_t h_visible_end = col_t'(h_visible);
  localparam col_t h_sync_start  = col_t'(h_visible + h_front_porch);
  localparam col_t h_sync_end    = col_t'(h_visible + h_front_porch + h_sync_pulse);
  localparam col_t h_last        = col_t'(h_whole_line - 1);

  localparam row_t v_visible_end = row_t'(v_visible);
  localparam row_t v_sync_start  = row_t'(v_visible + v_front_porch);
  localparam row_t v_sync_end    = row_t'(v_visible + v_front_porch + v_sync_pulse);
  localparam row_t v_last        = row_t'(v_whole_frame - 1);

endpackage

// ==== fb_pkg.sv ====
package fb_pkg;

  // 4 bits per channel, red then green then blue
  localparam int pixel_bits = 12;
  localparam int color_bits = 4;

  // the frame buffer is a 16-bit wide memory with one word per visible pixel
  localparam int fb_addr_width = 8;
  localparam int fb_data_width = 16;
  localparam int fb_words      = vga_timing_pkg::h_visible * vga_timing_pkg::v_visible;

  // only this many low address bits select a word inside the array
  localparam int fb_index_bits = $clog2(fb_words);

  // linear address, row * h_visible + column
  typedef logic [fb_addr_width-1:0] fb_addr_t;

  // colour sits in the top 12 bits and the low 4 bits are padding
  typedef logic [fb_data_width-1:0] fb_data_t;

  typedef logic [color_bits-1:0] color_t;

  // flags of one scan position, carried next to its outstanding read
  typedef struct packed {
    logic visible;
    logic vsync;
    logic hsync;
  } pixel_ctx_t;

  // one emitted scan position
  typedef struct packed {
    logic   hsync;
    logic   vsync;
    color_t red;
    color_t green;
    color_t blue;
  } pixel_out_t;

  // read address channel from the stream to the memory
  typedef struct packed {
    fb_addr_t araddr;
    logic     arvalid;
  } ar_req_t;

endpackage

// ==== vga_sync.sv ====
module vga_sync (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 step,
  output logic                 visible,
  output logic                 hsync,
  output logic                 vsync,
  output vga_timing_pkg::col_t column,
  output vga_timing_pkg::row_t row
);
  import vga_timing_pkg::*;

  logic in_h_visible;
  logic in_v_visible;
  logic in_h_pulse;
  logic in_v_pulse;

  // the scan walks every position of the frame, blanking included, and
  // moves by exactly one position per step
  always_ff @(posedge clk) begin
    if (reset) begin
      column <= '0;
      row    <= '0;
    end else if (step) begin
      if (column == h_last) begin
        column <= '0;
        // end of line, so move down or wrap to the top of the frame
        if (row == v_last) begin
          row <= '0;
        end else begin
          row <= row + 1'b1;
        end
      end else begin
        column <= column + 1'b1;
      end
    end
  end

  // everything below is decoded from the counters, so the flags change on
  // the same edge as the coordinates and hold while step is low
  assign in_h_visible = column < h_visible_end;
  assign in_v_visible = row < v_visible_end;

  assign visible = in_h_visible & in_v_visible;

  // sync pulse windows start after the front porch
  assign in_h_pulse = (column >= h_sync_start) && (column < h_sync_end);
  assign in_v_pulse = (row >= v_sync_start) && (row < v_sync_end);

  // with active-low polarity the xor drives the line low inside the pulse
  // and high everywhere else
  assign hsync = in_h_pulse ^ sync_active_low;
  assign vsync = in_v_pulse ^ sync_active_low;

endmodule

// ==== context_fifo.sv ====
module context_fifo #(
  parameter int depth = 4
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               write_en,
  input  logic               read_en,
  input  fb_pkg::pixel_ctx_t write_data,
  output fb_pkg::pixel_ctx_t read_data,
  output logic               empty,
  output logic               full
);
  import fb_pkg::*;

  localparam int ptr_bits   = (depth > 1) ? $clog2(depth) : 1;
  localparam int count_bits = $clog2(depth + 1);

  typedef logic [ptr_bits-1:0]   ptr_t;
  typedef logic [count_bits-1:0] count_t;

  pixel_ctx_t mem [depth];
  ptr_t       rd_ptr;
  ptr_t       wr_ptr;
  count_t     count;
  logic       do_write;
  logic       do_read;

  // pointers wrap at depth, which need not be a power of two
  function automatic ptr_t next_ptr(input ptr_t ptr);
    return (ptr == ptr_t'(depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign empty = count == '0;
  assign full  = count == count_t'(depth);

  // a write into a full buffer or a read from an empty one does nothing
  assign do_write = write_en & ~full;
  assign do_read  = read_en & ~empty;

  // first word fall through, the head is on the output while not empty
  // and read_en only retires it at the next edge
  assign read_data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_write) begin
      mem[wr_ptr] <= write_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_write) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_read) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      // simultaneous write and read leave the occupancy unchanged
      case ({do_write, do_read})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== vga_fb_pixel_stream.sv ====
module vga_fb_pixel_stream (
  input  logic               clk,
  input  logic               reset,
  input  logic               enable,
  output logic               valid,
  output fb_pkg::pixel_out_t pixel,
  output fb_pkg::ar_req_t    ar_req,
  input  logic               arready,
  input  fb_pkg::fb_data_t   rdata,
  input  logic               rvalid,
  output logic               rready
);
  import vga_timing_pkg::*;
  import fb_pkg::*;

  typedef enum logic {
    idle,
    reading
  } state_t;

  // current scan position straight from the counter
  logic       s_visible;
  logic       s_hsync;
  logic       s_vsync;
  col_t       s_column;
  row_t       s_row;
  fb_addr_t   addr_calc;

  state_t     state;
  state_t     next_state;
  logic       step;

  // p1 holds the position that was just stepped away from
  logic       p1_valid;
  pixel_ctx_t p1_ctx;
  fb_addr_t   p1_addr;

  logic       arvalid_q;
  fb_addr_t   araddr_q;
  logic       read_start;
  logic       read_accepted;
  logic       read_done;

  pixel_ctx_t head_ctx;
  logic       ctx_empty;
  logic       ctx_full;
  logic       pop;

  vga_sync sync (
    .clk    (clk),
    .reset  (reset),
    .step   (step),
    .visible(s_visible),
    .hsync  (s_hsync),
    .vsync  (s_vsync),
    .column (s_column),
    .row    (s_row)
  );

  // the address is only meaningful inside the visible area and is never
  // used for a blanking position
  assign addr_calc = fb_addr_t'(s_row) * fb_addr_t'(h_visible) + fb_addr_t'(s_column);

  assign read_accepted = arvalid_q & arready;
  assign read_done     = rvalid & rready;

  // idle means no read request is waiting for acceptance, so any enabled
  // position may step
  // reading covers the request from the step that created it until the
  // memory accepts it, and nothing else steps in that window, which bounds
  // the context fifo to two entries in flight
  always_comb begin
    next_state = state;
    step       = 1'b0;
    case (state)
      idle: begin
        step = enable & ~ctx_full;
        if (step && s_visible) begin
          next_state = reading;
        end
      end
      reading: begin
        if (read_accepted) begin
          // the next read may be requested in the same cycle as acceptance
          step       = enable & ~ctx_full;
          next_state = (step && s_visible) ? reading : idle;
        end
      end
      default: next_state = idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= idle;
    end else begin
      state <= next_state;
    end
  end

  // a fresh register stage between the address multiply and the memory
  always_ff @(posedge clk) begin
    if (reset) begin
      p1_valid <= 1'b0;
    end else begin
      p1_valid <= step;
    end
  end

  always_ff @(posedge clk) begin
    if (step) begin
      p1_ctx.visible <= s_visible;
      p1_ctx.vsync   <= s_vsync;
      p1_ctx.hsync   <= s_hsync;
      p1_addr        <= addr_calc;
    end
  end

  // p1 always leaves on the following cycle, and for a visible position the
  // address channel is guaranteed free by then
  assign read_start = p1_valid & p1_ctx.visible;

  always_ff @(posedge clk) begin
    if (reset) begin
      arvalid_q <= 1'b0;
    end else if (read_start) begin
      arvalid_q <= 1'b1;
    end else if (read_accepted) begin
      arvalid_q <= 1'b0;
    end
  end

  // the address stays put until the request is accepted
  always_ff @(posedge clk) begin
    if (read_start) begin
      araddr_q <= p1_addr;
    end
  end

  assign ar_req.araddr  = araddr_q;
  assign ar_req.arvalid = arvalid_q;

  // output assembly never stalls, so the response channel is always ready
  always_ff @(posedge clk) begin
    if (reset) begin
      rready <= 1'b0;
    end else begin
      rready <= 1'b1;
    end
  end

  // every position leaving p1 queues its flags, so each returning word is
  // matched to the position that asked for it and blanking positions keep
  // their place in scan order
  context_fifo #(
    .depth(4)
  ) ctx_fifo (
    .clk       (clk),
    .reset     (reset),
    .write_en  (p1_valid),
    .read_en   (pop),
    .write_data(p1_ctx),
    .read_data (head_ctx),
    .empty     (ctx_empty),
    .full      (ctx_full)
  );

  // a blanking head goes out at once, a visible one waits for its word
  assign pop = ~ctx_empty & (~head_ctx.visible | read_done);

  // pixel holds between strobes, and out of reset both syncs are inactive
  always_ff @(posedge clk) begin
    if (reset) begin
      valid       <= 1'b0;
      pixel.hsync <= sync_active_low;
      pixel.vsync <= sync_active_low;
      pixel.red   <= '0;
      pixel.green <= '0;
      pixel.blue  <= '0;
    end else begin
      valid <= pop;
      if (pop) begin
        pixel.hsync <= head_ctx.hsync;
        pixel.vsync <= head_ctx.vsync;
        // colour comes from the top of the word and the padding is dropped
        if (head_ctx.visible) begin
          {pixel.red, pixel.green, pixel.blue} <= rdata[fb_data_width-1 -: pixel_bits];
        end else begin
          {pixel.red, pixel.green, pixel.blue} <= '0;
        end
      end
    end
  end

endmodule

// ==== fb_sram.sv ====
module fb_sram (
  input  logic             clk,
  input  logic             reset,
  input  fb_pkg::ar_req_t  ar_req,
  output logic             arready,
  output fb_pkg::fb_data_t rdata,
  output logic             rvalid,
  input  logic             rready,
  input  logic             wr_en,
  input  fb_pkg::fb_addr_t wr_addr,
  input  fb_pkg::fb_data_t wr_data
);
  import fb_pkg::*;

  fb_data_t mem [fb_words];
  logic     read_accepted;
  logic     read_done;

  // one read at a time, a new address is taken only once the previous
  // word has been handed over
  assign arready = ~rvalid;

  assign read_accepted = ar_req.arvalid & arready;
  assign read_done     = rvalid & rready;

  // rvalid doubles as the response-pending flag and rises the cycle after
  // the address is accepted
  always_ff @(posedge clk) begin
    if (reset) begin
      rvalid <= 1'b0;
    end else if (read_accepted) begin
      rvalid <= 1'b1;
    end else if (read_done) begin
      rvalid <= 1'b0;
    end
  end

  // the word is latched on acceptance and stays on rdata until taken
  // both ports sample the array before the edge, so a read of the word
  // being written returns the old contents
  always_ff @(posedge clk) begin
    if (read_accepted) begin
      rdata <= mem[ar_req.araddr[fb_index_bits-1:0]];
    end
    if (wr_en) begin
      mem[wr_addr[fb_index_bits-1:0]] <= wr_data;
    end
  end

endmodule

// ==== vga_fb_top.sv ====
module vga_fb_top (
  input  logic               clk,
  input  logic               reset,
  input  logic               enable,
  input  logic               wr_en,
  input  fb_pkg::fb_addr_t   wr_addr,
  input  fb_pkg::fb_data_t   wr_data,
  output logic               valid,
  output fb_pkg::pixel_out_t pixel
);
  import fb_pkg::*;

  // read channel between the stream and the frame buffer
  ar_req_t  ar_req;
  logic     arready;
  fb_data_t rdata;
  logic     rvalid;
  logic     rready;

  vga_fb_pixel_stream stream (
    .clk    (clk),
    .reset  (reset),
    .enable (enable),
    .valid  (valid),
    .pixel  (pixel),
    .ar_req (ar_req),
    .arready(arready),
    .rdata  (rdata),
    .rvalid (rvalid),
    .rready (rready)
  );

  // the write port is only used to load the frame while the scan is stopped
  fb_sram fb (
    .clk    (clk),
    .reset  (reset),
    .ar_req (ar_req),
    .arready(arready),
    .rdata  (rdata),
    .rvalid (rvalid),
    .rready (rready),
    .wr_en  (wr_en),
    .wr_addr(wr_addr),
    .wr_data(wr_data)
  );

endmodule

// ==== tb_vga_fb.sv ====
module tb_vga_fb;
  timeunit 1ns;
  timeprecision 100ps;
  import vga_timing_pkg::*;
  import fb_pkg::*;

  localparam int   frame_positions = h_whole_line * v_whole_frame;
  localparam int   strobe_timeout  = 200;
  // inactive sync level, high for the usual active-low polarity
  localparam logic sync_idle       = sync_active_low;

  logic        clk;
  logic        reset;
  logic        enable;
  logic        wr_en;
  fb_addr_t    wr_addr;
  fb_data_t    wr_data;
  logic        valid;
  pixel_out_t  pixel;

  logic [31:0] lfsr_state;
  fb_data_t    shadow [fb_words];
  // software scan position, stepped once per observed strobe
  int          model_col;
  int          model_row;
  int          strobe_total;
  int          last_vsync_index;
  logic        prev_vsync_pulse;
  logic        strobe_seen;

  vga_fb_top dut (
    .clk    (clk),
    .reset  (reset),
    .enable (enable),
    .wr_en  (wr_en),
    .wr_addr(wr_addr),
    .wr_data(wr_data),
    .valid  (valid),
    .pixel  (pixel)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // galois form, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  // each bit taken costs one lfsr step
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v          = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
  endfunction

  // what the output should carry for one scan position
  function automatic pixel_out_t expected_pixel(input int col, input int row);
    pixel_out_t e;
    logic       h_pulse;
    logic       v_pulse;
    h_pulse = (col >= h_visible + h_front_porch) &&
              (col < h_visible + h_front_porch + h_sync_pulse);
    v_pulse = (row >= v_visible + v_front_porch) &&
              (row < v_visible + v_front_porch + v_sync_pulse);
    e.hsync = sync_active_low ? ~h_pulse : h_pulse;
    e.vsync = sync_active_low ? ~v_pulse : v_pulse;
    // blanking is black whatever the memory holds
    if (col < h_visible && row < v_visible) begin
      {e.red, e.green, e.blue} = shadow[row * h_visible + col][fb_data_width-1 -: pixel_bits];
    end else begin
      {e.red, e.green, e.blue} = '0;
    end
    return e;
  endfunction

  task automatic fail_now();
    $display("SOME TESTS FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_pixel(input pixel_out_t got, input pixel_out_t exp);
    if (got !== exp) begin
      $display("ERR %0t pixel got=%h expected=%h at column %0d row %0d",
               $time, got, exp, model_col, model_row);
      fail_now();
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("ERR %0t %s got=%0d expected=%0d", $time, name, got, exp);
      fail_now();
    end
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERR %0t %s got=%b expected=%b", $time, name, got, exp);
      fail_now();
    end
  endtask

  // compare one strobe with the model, then move the model on by one position
  task automatic observe();
    logic pulse;
    pulse = (pixel.vsync != sync_idle);
    // frame length is measured between vsync leading edges on the output,
    // so a lost or repeated strobe just before the edge shows up as a count
    if (pulse && !prev_vsync_pulse) begin
      if (last_vsync_index >= 0) begin
        check_count("strobes per frame", strobe_total - last_vsync_index, frame_positions);
      end
      last_vsync_index = strobe_total;
    end
    prev_vsync_pulse = pulse;
    check_pixel(pixel, expected_pixel(model_col, model_row));
    strobe_total++;
    model_col++;
    if (model_col == h_whole_line) begin
      model_col = 0;
      model_row = (model_row == v_whole_frame - 1) ? 0 : model_row + 1;
    end
  endtask

  // outputs are stable at the falling edge, and inputs change there too
  task automatic tick();
    @(negedge clk);
    strobe_seen = valid;
    if (!reset && valid) begin
      observe();
    end
  endtask

  task automatic wait_strobes(input int target, input bit random_enable);
    int          quiet;
    logic [31:0] coin;
    quiet = 0;
    while (strobe_total < target) begin
      tick();
      if (random_enable) begin
        coin   = rand_bits(1);
        enable = coin[0];
      end
      quiet = strobe_seen ? 0 : quiet + 1;
      if (quiet > strobe_timeout) begin
        $display("timeout, no pixel strobe within %0d cycles", strobe_timeout);
        fail_now();
      end
    end
  endtask

  // with enable low, wait for the in-flight positions and then expect silence
  task automatic drain_and_hold();
    int quiet;
    int cycles;
    int held;
    quiet  = 0;
    cycles = 0;
    while (quiet < 8) begin
      tick();
      quiet = strobe_seen ? 0 : quiet + 1;
      cycles++;
      if (cycles > strobe_timeout) begin
        $display("pipeline kept strobing after enable went low");
        fail_now();
      end
    end
    held = strobe_total;
    repeat (50) tick();
    check_count("strobes after drain", strobe_total, held);
  endtask

  task automatic load_frame();
    logic [31:0] word;
    for (int a = 0; a < fb_words; a++) begin
      tick();
      word      = rand_bits(fb_data_width);
      wr_en     = 1'b1;
      wr_addr   = fb_addr_t'(a);
      wr_data   = word[fb_data_width-1:0];
      shadow[a] = word[fb_data_width-1:0];
    end
    tick();
    wr_en = 1'b0;
  endtask

  initial begin
    pixel_out_t idle_px;
    lfsr_state       = 32'h32c3;
    reset            = 1'b1;
    enable           = 1'b0;
    wr_en            = 1'b0;
    wr_addr          = '0;
    wr_data          = '0;
    model_col        = 0;
    model_row        = 0;
    strobe_total     = 0;
    last_vsync_index = -1;
    prev_vsync_pulse = 1'b0;
    strobe_seen      = 1'b0;
    idle_px.hsync    = sync_idle;
    idle_px.vsync    = sync_idle;
    idle_px.red      = '0;
    idle_px.green    = '0;
    idle_px.blue     = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // quiet outputs before the consumer asks for anything
    repeat (20) begin
      tick();
      check_level("valid", valid, 1'b0);
      check_pixel(pixel, idle_px);
    end

    // two whole frames with enable held high
    load_frame();
    enable = 1'b1;
    wait_strobes(2 * frame_positions, 1'b0);

    // stop inside vertical blanking so no visible read is in flight
    wait_strobes(2 * frame_positions + (v_visible + v_front_porch + 1) * h_whole_line, 1'b0);
    enable = 1'b0;
    drain_and_hold();
    load_frame();
    enable = 1'b1;
    wait_strobes(4 * frame_positions, 1'b0);

    // consumer that stalls at random, then a final stop
    wait_strobes(5 * frame_positions + 100, 1'b1);
    enable = 1'b0;
    drain_and_hold();

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// ==== filelist.f ====
vga_timing_pkg.sv
fb_pkg.sv
vga_sync.sv
context_fifo.sv
vga_fb_pixel_stream.sv
fb_sram.sv
vga_fb_top.sv
tb_vga_fb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FILELIST  ?= filelist.f
TOP       ?= tb_vga_fb
RTL_TOP   ?= vga_fb_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
